/* Bender.yml */
package:
  name: address_unit

sources:
  - source/addressPkg.sv
  - source/modeDecoder.sv
  - source/modeSequencer.sv
  - source/addressingFlags.sv
  - source/programCounter.sv
  - source/addressDatapath.sv
  - source/addressUnit.sv
  - target: simulation
    files:
      - sim/addressUnitTb.sv

/* all.f */
source/addressPkg.sv
source/modeDecoder.sv
source/modeSequencer.sv
source/addressingFlags.sv
source/programCounter.sv
source/addressDatapath.sv
source/addressUnit.sv
sim/addressUnitTb.sv

/* sim/addressUnitTb.sv */
module addressUnitTb;

    localparam int clockPeriod = 40;
    localparam int driveDelay = 2;
    localparam int resetCycles = 5;
    localparam int testCount = 11;
    localparam int cyclesPerTest = 10;
    localparam int cycleLimit = resetCycles + cyclesPerTest * testCount;
    localparam int randomSeed = 52;

    typedef struct packed {
        addressPkg::byteT opCode;
        addressPkg::byteT xValue;
        addressPkg::byteT yValue;
        addressPkg::addressT startPc;
        addressPkg::byteT operandLow;
        addressPkg::byteT operandHigh;
        addressPkg::addressT expectedAddress;
        addressPkg::addressT expectedPc;
        logic [15:0] expectedCycles;
        logic restart;
    } testRow;

    logic clk;
    logic reset;
    logic start;
    addressPkg::byteT opCode;
    addressPkg::byteT dataIn;
    logic loadX;
    logic loadY;
    addressPkg::byteT regValue;
    logic loadPc;
    addressPkg::addressT pcValue;
    addressPkg::addressT address;
    addressPkg::addressT pc;
    logic busy;
    logic done;

    addressPkg::byteT memory [0:65535];
    testRow tests [testCount];
    string testNames [testCount];
    int rowCount;
    int errorCount;
    int passCount;
    int failCount;
    int cycleCount;

    addressUnit dut (
        .clk(clk),
        .reset(reset),
        .start(start),
        .opCode(opCode),
        .dataIn(dataIn),
        .loadX(loadX),
        .loadY(loadY),
        .regValue(regValue),
        .loadPc(loadPc),
        .pcValue(pcValue),
        .address(address),
        .pc(pc),
        .busy(busy),
        .done(done)
    );

    // Combinational memory read
    assign dataIn = memory[address];

    initial begin
        clk = 1'b0;
        forever begin
            #(clockPeriod / 2) clk = ~clk;
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", cycleLimit);
        $display("TEST FAIL");
        $finish;
    end

    task automatic nextCycle();
        @(posedge clk);
        #driveDelay;
    endtask

    task automatic checkValue(input string testName, input string label,
                              input logic [15:0] expected, input logic [15:0] actual);
        if (actual !== expected) begin
            $display("ERR %s %s expected %h actual %h", testName, label, expected, actual);
            errorCount++;
        end
    endtask

    task automatic addRow(input string name, input addressPkg::byteT op,
                          input addressPkg::byteT x, input addressPkg::byteT y,
                          input addressPkg::addressT startPc,
                          input addressPkg::byteT low, input addressPkg::byteT high,
                          input addressPkg::addressT expAddress,
                          input addressPkg::addressT expPc, input logic [15:0] cycles,
                          input logic restart);
        testNames[rowCount] = name;
        tests[rowCount].opCode = op;
        tests[rowCount].xValue = x;
        tests[rowCount].yValue = y;
        tests[rowCount].startPc = startPc;
        tests[rowCount].operandLow = low;
        tests[rowCount].operandHigh = high;
        tests[rowCount].expectedAddress = expAddress;
        tests[rowCount].expectedPc = expPc;
        tests[rowCount].expectedCycles = cycles;
        tests[rowCount].restart = restart;
        rowCount++;
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore) begin
            $display("%s: ok", name);
            passCount++;
        end else begin
            $display("%s: failed", name);
            failCount++;
        end
    endtask

    task automatic runRow(input int index);
        testRow row;
        string name;
        addressPkg::addressT nextPc;
        int errorsBefore;
        logic [15:0] cycles;
        logic doneSeen;
        row = tests[index];
        name = testNames[index];
        nextPc = row.startPc + 16'd1;
        errorsBefore = errorCount;

        // Operands, X and PC in the first idle cycle
        nextCycle();
        memory[row.startPc] = row.operandLow;
        memory[nextPc] = row.operandHigh;
        loadX = 1'b1;
        regValue = row.xValue;
        loadPc = 1'b1;
        pcValue = row.startPc;
        nextCycle();
        loadX = 1'b0;
        loadPc = 1'b0;
        loadY = 1'b1;
        regValue = row.yValue;
        nextCycle();
        loadY = 1'b0;
        start = 1'b1;
        opCode = row.opCode;

        // Start edge
        nextCycle();
        start = 1'b0;
        if (row.restart) begin
            checkValue(name, "busy", 16'd1, {15'd0, busy});
            // A different mode that must not be latched
            start = 1'b1;
            opCode = addressPkg::opLdaAbsX;
        end

        doneSeen = 1'b0;
        cycles = 16'd0;
        while (!doneSeen) begin
            nextCycle();
            start = 1'b0;
            cycles = cycles + 16'd1;
            doneSeen = done;
        end
        checkValue(name, "cycles", row.expectedCycles, cycles);
        checkValue(name, "address", row.expectedAddress, address);
        checkValue(name, "pc", row.expectedPc, pc);

        // Exactly one done pulse
        nextCycle();
        checkValue(name, "done", 16'd0, {15'd0, done});
        checkValue(name, "busy", 16'd0, {15'd0, busy});
        reportTest(name, errorsBefore);
    endtask

    initial begin
        int seedDummy;
        int randomWord;
        int errorsBefore;
        reset = 1'b1;
        start = 1'b0;
        opCode = 8'h00;
        loadX = 1'b0;
        loadY = 1'b0;
        regValue = 8'h00;
        loadPc = 1'b0;
        pcValue = 16'h0000;
        rowCount = 0;
        errorCount = 0;
        passCount = 0;
        failCount = 0;

        seedDummy = $urandom(randomSeed);
        for (int i = 0; i < 65536; i++) begin
            randomWord = $urandom;
            memory[i] = randomWord[7:0];
        end

        // name, opcode, X, Y, PC, low, high, expected address, pc and cycles, restart
        addRow("immediate", addressPkg::opLdaImm, 8'h00, 8'h00, 16'h0300, 8'h5A, 8'h00,
               16'h0300, 16'h0301, 16'd2, 1'b0);
        addRow("zeroPage", addressPkg::opLdaZpg, 8'h00, 8'h00, 16'h0310, 8'h84, 8'h00,
               16'h0084, 16'h0311, 16'd2, 1'b0);
        addRow("absolute", addressPkg::opLdaAbs, 8'h00, 8'h00, 16'h0320, 8'h34, 8'h12,
               16'h1234, 16'h0322, 16'd3, 1'b0);
        addRow("absXNoCross", addressPkg::opLdaAbsX, 8'h05, 8'h00, 16'h0330, 8'h10, 8'h20,
               16'h2015, 16'h0332, 16'd4, 1'b0);
        addRow("absXCross", addressPkg::opLdaAbsX, 8'hF0, 8'h00, 16'h0340, 8'h30, 8'h45,
               16'h4620, 16'h0342, 16'd4, 1'b0);
        addRow("absXIgnoresY", addressPkg::opLdaAbsX, 8'h02, 8'h40, 16'h0370, 8'h00, 8'h90,
               16'h9002, 16'h0372, 16'd4, 1'b0);
        addRow("absYCross", addressPkg::opLdaAbsY, 8'h00, 8'h81, 16'h0350, 8'hC0, 8'h7E,
               16'h7F41, 16'h0352, 16'd4, 1'b0);
        addRow("absYWrap", addressPkg::opLdaAbsY, 8'h00, 8'h03, 16'h0360, 8'hFF, 8'hFF,
               16'h0002, 16'h0362, 16'd4, 1'b0);
        // Operand bytes straddle a page
        addRow("absYPageEnd", addressPkg::opLdaAbsY, 8'h00, 8'h01, 16'h03FF, 8'hFF, 8'h12,
               16'h1300, 16'h0401, 16'd4, 1'b0);
        addRow("nop", addressPkg::opNop, 8'h11, 8'h22, 16'h0380, 8'h00, 8'h00,
               16'h0380, 16'h0380, 16'd1, 1'b0);
        addRow("unknownRestart", 8'h02, 8'h33, 8'h44, 16'h0390, 8'h00, 8'h00,
               16'h0390, 16'h0390, 16'd1, 1'b1);

        repeat (resetCycles) @(posedge clk);
        #driveDelay;
        reset = 1'b0;
        errorsBefore = errorCount;
        checkValue("reset", "address", addressPkg::resetVector, address);
        checkValue("reset", "pc", addressPkg::resetVector, pc);
        checkValue("reset", "busy", 16'd0, {15'd0, busy});
        checkValue("reset", "done", 16'd0, {15'd0, done});
        reportTest("reset", errorsBefore);

        for (int i = 0; i < rowCount; i++) begin
            runRow(i);
        end

        $display("Tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* source/addressDatapath.sv */
module addressDatapath (
    input  logic                    clk,
    input  logic                    reset,
    input  addressPkg::controlFlags flags,
    input  addressPkg::byteT        dataIn,
    input  addressPkg::addressT     pcNext,
    input  logic                    loadX,
    input  logic                    loadY,
    input  addressPkg::byteT        regValue,
    output addressPkg::addressT     address
);

    addressPkg::byteT xReg;
    addressPkg::byteT yReg;
    addressPkg::byteT dataBus;
    addressPkg::byteT specialBus;
    addressPkg::byteT adlBus;
    addressPkg::byteT adhBus;
    addressPkg::byteT aInput;
    addressPkg::byteT bInput;
    addressPkg::byteT bReg;
    addressPkg::byteT aluResult;
    addressPkg::byteT abl;
    addressPkg::byteT abh;
    logic carry;
    logic [8:0] sum;

    assign dataBus = flags[addressPkg::setDbToData] ? dataIn : 8'h00;

    always_comb begin
        if (flags[addressPkg::setSbToX]) begin
            specialBus = xReg;
        end else if (flags[addressPkg::setSbToY]) begin
            specialBus = yReg;
        end else if (flags[addressPkg::setSbToAlu]) begin
            specialBus = aluResult;
        end else if (flags[addressPkg::setSbToDb]) begin
            specialBus = dataBus;
        end else begin
            specialBus = 8'h00;
        end
    end

    always_comb begin
        if (flags[addressPkg::setAdlToData]) begin
            adlBus = dataIn;
        end else if (flags[addressPkg::setAdlToPcl]) begin
            adlBus = pcNext[7:0];
        end else if (flags[addressPkg::setAdlToAlu]) begin
            adlBus = aluResult;
        end else begin
            adlBus = 8'h00;
        end
    end

    // setAdhLow forces the zero page
    always_comb begin
        if (flags[addressPkg::setAdhLow]) begin
            adhBus = 8'h00;
        end else if (flags[addressPkg::setAdhToPch]) begin
            adhBus = pcNext[15:8];
        end else if (flags[addressPkg::setAdhToSb]) begin
            adhBus = specialBus;
        end else begin
            adhBus = 8'h00;
        end
    end

    assign aInput = flags[addressPkg::setInputAToSb] ? specialBus : 8'h00;
    // B latch is transparent while loading
    assign bInput = flags[addressPkg::setInputBToDb] ? dataBus : bReg;

    // Carry mode adds only the saved carry to B
    assign sum = flags[addressPkg::aluUseCarry] ? {1'b0, bInput} + {8'd0, carry}
                                                : {1'b0, aInput} + {1'b0, bInput};

    always_ff @(posedge clk) begin
        if (flags[addressPkg::setInputBToDb]) begin
            bReg <= dataBus;
        end
        if (flags[addressPkg::aluAdd]) begin
            aluResult <= sum[7:0];
            carry <= sum[8];
        end else if (flags[addressPkg::setInputBToDb]) begin
            aluResult <= bInput;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            xReg <= 8'h00;
            yReg <= 8'h00;
            abl <= addressPkg::resetVector[7:0];
            abh <= addressPkg::resetVector[15:8];
        end else begin
            if (loadX) begin
                xReg <= regValue;
            end
            if (loadY) begin
                yReg <= regValue;
            end
            if (flags[addressPkg::loadAbl]) begin
                abl <= adlBus;
            end
            if (flags[addressPkg::loadAbh]) begin
                abh <= adhBus;
            end
        end
    end

    assign address = {abh, abl};

endmodule

/* source/addressPkg.sv */
package addressPkg;

    // Data and address widths
    typedef logic [7:0] byteT;
    typedef logic [15:0] addressT;

    localparam int flagCount = 19;
    typedef logic [flagCount-1:0] controlFlags;

    // Flag bit positions with bit 16 left unused
    localparam int setAdhLow = 0;
    localparam int setAdlToData = 1;
    localparam int loadAbl = 2;
    localparam int loadAbh = 3;
    localparam int pcInc = 4;
    localparam int aluUseCarry = 5;
    localparam int setAdlToPcl = 6;
    localparam int setAdhToPch = 7;
    localparam int setDbToData = 8;
    localparam int setInputBToDb = 9;
    localparam int setSbToDb = 10;
    localparam int setAdlToAlu = 11;
    localparam int setAdhToSb = 12;
    localparam int setInputAToSb = 13;
    localparam int setSbToX = 14;
    localparam int setSbToY = 15;
    localparam int setSbToAlu = 17;
    localparam int aluAdd = 18;

    typedef enum logic [2:0] {
        modeImplied,
        modeImmediate,
        modeZeroPage,
        modeAbsolute,
        modeAbsoluteX,
        modeAbsoluteY
    } addrMode;

    typedef enum logic [2:0] {
        stateIdle,
        stateFetch,
        stateA0,
        stateA1,
        stateA2
    } seqState;

    // Supported opcodes
    localparam byteT opLdaImm = 8'hA9;
    localparam byteT opLdaZpg = 8'hA5;
    localparam byteT opLdaAbs = 8'hAD;
    localparam byteT opLdaAbsX = 8'hBD;
    localparam byteT opLdaAbsY = 8'hB9;
    localparam byteT opNop = 8'hEA;

    localparam addressT resetVector = 16'h0200;

endpackage

/* source/addressUnit.sv */
module addressUnit (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  addressPkg::byteT    opCode,
    input  addressPkg::byteT    dataIn,
    input  logic                loadX,
    input  logic                loadY,
    input  addressPkg::byteT    regValue,
    input  logic                loadPc,
    input  addressPkg::addressT pcValue,
    output addressPkg::addressT address,
    output addressPkg::addressT pc,
    output logic                busy,
    output logic                done
);

    addressPkg::addrMode mode;
    addressPkg::addrMode latchedMode;
    addressPkg::seqState state;
    addressPkg::controlFlags flags;
    addressPkg::addressT pcNext;

    modeDecoder decoder (
        .opCode(opCode),
        .mode(mode)
    );

    modeSequencer sequencer (
        .clk(clk),
        .reset(reset),
        .start(start),
        .mode(mode),
        .state(state),
        .latchedMode(latchedMode),
        .busy(busy),
        .done(done)
    );

    addressingFlags flagTable (
        .state(state),
        .latchedMode(latchedMode),
        .flags(flags)
    );

    programCounter counter (
        .clk(clk),
        .reset(reset),
        .loadPc(loadPc),
        .pcValue(pcValue),
        .inc(flags[addressPkg::pcInc]),
        .pc(pc),
        .pcNext(pcNext)
    );

    addressDatapath datapath (
        .clk(clk),
        .reset(reset),
        .flags(flags),
        .dataIn(dataIn),
        .pcNext(pcNext),
        .loadX(loadX),
        .loadY(loadY),
        .regValue(regValue),
        .address(address)
    );

endmodule

/* source/addressingFlags.sv */
module addressingFlags (
    input  addressPkg::seqState     state,
    input  addressPkg::addrMode     latchedMode,
    output addressPkg::controlFlags flags
);

    // AB picks up the current PC in every mode
    function automatic addressPkg::controlFlags fetchFlags();
        addressPkg::controlFlags f;
        f = '0;
        f[addressPkg::setAdlToPcl] = 1'b1;
        f[addressPkg::setAdhToPch] = 1'b1;
        f[addressPkg::loadAbl] = 1'b1;
        f[addressPkg::loadAbh] = 1'b1;
        return f;
    endfunction

    function automatic addressPkg::controlFlags immediateFlags(addressPkg::seqState s);
        addressPkg::controlFlags f;
        f = '0;
        if (s == addressPkg::stateA0) begin
            // Step past the operand while AB stays on it
            f[addressPkg::pcInc] = 1'b1;
        end
        return f;
    endfunction

    function automatic addressPkg::controlFlags zeroPageFlags(addressPkg::seqState s);
        addressPkg::controlFlags f;
        f = '0;
        if (s == addressPkg::stateA0) begin
            f[addressPkg::setAdhLow] = 1'b1;
            f[addressPkg::setAdlToData] = 1'b1;
            f[addressPkg::loadAbl] = 1'b1;
            f[addressPkg::loadAbh] = 1'b1;
            f[addressPkg::pcInc] = 1'b1;
        end
        return f;
    endfunction

    function automatic addressPkg::controlFlags absoluteFlags(addressPkg::seqState s);
        addressPkg::controlFlags f;
        f = '0;
        if (s == addressPkg::stateA0) begin
            // Point AB at the high byte
            f[addressPkg::pcInc] = 1'b1;
            f[addressPkg::setAdlToPcl] = 1'b1;
            f[addressPkg::setAdhToPch] = 1'b1;
            f[addressPkg::loadAbl] = 1'b1;
            f[addressPkg::loadAbh] = 1'b1;
            // Park low byte in the adder
            f[addressPkg::setDbToData] = 1'b1;
            f[addressPkg::setInputBToDb] = 1'b1;
        end else if (s == addressPkg::stateA1) begin
            f[addressPkg::pcInc] = 1'b1;
            f[addressPkg::setAdlToAlu] = 1'b1;
            f[addressPkg::loadAbl] = 1'b1;
            // High byte straight through DB and SB
            f[addressPkg::setDbToData] = 1'b1;
            f[addressPkg::setSbToDb] = 1'b1;
            f[addressPkg::setAdhToSb] = 1'b1;
            f[addressPkg::loadAbh] = 1'b1;
        end
        return f;
    endfunction

    // Absolute X and Y differ only in the register that indexFlag puts on SB
    function automatic addressPkg::controlFlags indexedFlags(addressPkg::seqState s,
                                                             int indexFlag);
        addressPkg::controlFlags f;
        f = '0;
        if (s == addressPkg::stateA0) begin
            f[addressPkg::pcInc] = 1'b1;
            f[addressPkg::setAdlToPcl] = 1'b1;
            f[addressPkg::setAdhToPch] = 1'b1;
            f[addressPkg::loadAbl] = 1'b1;
            f[addressPkg::loadAbh] = 1'b1;
            // Low byte plus index
            f[addressPkg::aluAdd] = 1'b1;
            f[addressPkg::setDbToData] = 1'b1;
            f[addressPkg::setInputBToDb] = 1'b1;
            f[indexFlag] = 1'b1;
            f[addressPkg::setInputAToSb] = 1'b1;
        end else if (s == addressPkg::stateA1) begin
            f[addressPkg::pcInc] = 1'b1;
            f[addressPkg::setAdlToAlu] = 1'b1;
            f[addressPkg::loadAbl] = 1'b1;
            // High byte plus carry only
            f[addressPkg::aluAdd] = 1'b1;
            f[addressPkg::aluUseCarry] = 1'b1;
            f[addressPkg::setDbToData] = 1'b1;
            f[addressPkg::setInputBToDb] = 1'b1;
        end else if (s == addressPkg::stateA2) begin
            f[addressPkg::setSbToAlu] = 1'b1;
            f[addressPkg::setAdhToSb] = 1'b1;
            f[addressPkg::loadAbh] = 1'b1;
        end
        return f;
    endfunction

    always_comb begin
        flags = '0;
        if (state == addressPkg::stateFetch) begin
            flags = fetchFlags();
        end else begin
            case (latchedMode)
                addressPkg::modeImmediate: flags = immediateFlags(state);
                addressPkg::modeZeroPage: flags = zeroPageFlags(state);
                addressPkg::modeAbsolute: flags = absoluteFlags(state);
                addressPkg::modeAbsoluteX: flags = indexedFlags(state, addressPkg::setSbToX);
                addressPkg::modeAbsoluteY: flags = indexedFlags(state, addressPkg::setSbToY);
                default: flags = '0;
            endcase
        end
    end

endmodule

/* source/modeDecoder.sv */
module modeDecoder (
    input  addressPkg::byteT    opCode,
    output addressPkg::addrMode mode
);

    always_comb begin
        case (opCode)
            addressPkg::opLdaImm: begin
                mode = addressPkg::modeImmediate;
            end
            addressPkg::opLdaZpg: begin
                mode = addressPkg::modeZeroPage;
            end
            addressPkg::opLdaAbs: begin
                mode = addressPkg::modeAbsolute;
            end
            addressPkg::opLdaAbsX: begin
                mode = addressPkg::modeAbsoluteX;
            end
            addressPkg::opLdaAbsY: begin
                mode = addressPkg::modeAbsoluteY;
            end
            addressPkg::opNop: begin
                mode = addressPkg::modeImplied;
            end
            default: begin
                // Anything unknown runs as a one-cycle implied op
                mode = addressPkg::modeImplied;
            end
        endcase
    end

endmodule

/* source/modeSequencer.sv */
module modeSequencer (
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  addressPkg::addrMode mode,
    output addressPkg::seqState state,
    output addressPkg::addrMode latchedMode,
    output logic                busy,
    output logic                done
);

    addressPkg::seqState nextState;

    always_comb begin
        nextState = state;
        case (state)
            addressPkg::stateIdle: begin
                if (start) begin
                    nextState = addressPkg::stateFetch;
                end
            end
            addressPkg::stateFetch: begin
                if (latchedMode == addressPkg::modeImplied) begin
                    nextState = addressPkg::stateIdle;
                end else begin
                    nextState = addressPkg::stateA0;
                end
            end
            addressPkg::stateA0: begin
                // One operand byte ends here
                if (latchedMode == addressPkg::modeImmediate ||
                    latchedMode == addressPkg::modeZeroPage) begin
                    nextState = addressPkg::stateIdle;
                end else begin
                    nextState = addressPkg::stateA1;
                end
            end
            addressPkg::stateA1: begin
                if (latchedMode == addressPkg::modeAbsolute) begin
                    nextState = addressPkg::stateIdle;
                end else begin
                    nextState = addressPkg::stateA2;
                end
            end
            default: begin
                nextState = addressPkg::stateIdle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= addressPkg::stateIdle;
            latchedMode <= addressPkg::modeImplied;
            done <= 1'b0;
        end else begin
            state <= nextState;
            if (state == addressPkg::stateIdle && start) begin
                latchedMode <= mode;
            end
            done <= (state != addressPkg::stateIdle) &&
                    (nextState == addressPkg::stateIdle);
        end
    end

    assign busy = (state != addressPkg::stateIdle);

endmodule

/* source/programCounter.sv */
module programCounter (
    input  logic                clk,
    input  logic                reset,
    input  logic                loadPc,
    input  addressPkg::addressT pcValue,
    input  logic                inc,
    output addressPkg::addressT pc,
    output addressPkg::addressT pcNext
);

    // Incremented value is visible in the same cycle
    assign pcNext = inc ? pc + 16'd1 : pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= addressPkg::resetVector;
        end else if (loadPc) begin
            pc <= pcValue;
        end else begin
            pc <= pcNext;
        end
    end

endmodule
